// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the PE testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary -f sim.f --top-module pe_tb -o pe_tb > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/pe_tb > sim.log 2>&1
cat sim.log
grep -qx "Test completed successfully" sim.log && exit 0 || exit 1

// ==== sim.f ====
verilog/pe_cfg_pkg.sv
verilog/pe_types_pkg.sv
verilog/pe_weight_load_if.sv
verilog/pe_sequencer.sv
verilog/pe_forward_stage.sv
verilog/pe_weight_mem.sv
verilog/pe_dot_array.sv
verilog/pe_accumulator.sv
verilog/pe_top.sv
sim/pe_checker.sv
sim/pe_tb.sv

// ==== sim/pe_checker.sv ====
`default_nettype none

module pe_checker #(
	parameter int ROWS = 3,
	parameter int WINDOW = 4
) (
	input wire clk,
	input wire i_reset,
	input wire i_valid,
	input wire pe_types_pkg::feature_vec_t i_features,
	input wire pe_types_pkg::feature_vec_t i_out_features,
	input wire pe_types_pkg::acc_t [ROWS-1:0] i_result,
	input wire i_out_valid,
	input wire i_next_valid,
	input wire i_next_reset
);

	typedef pe_types_pkg::acc_t [ROWS-1:0] result_vec_t;

	result_vec_t exp_q [$];
	int result_errors = 0;
	int timing_errors = 0;
	int forward_errors = 0;
	int other_errors = 0;
	int beat_count = 0;
	// Bit 3 set means o_valid is due in the current cycle
	logic [3:0] last_pipe = '0;
	logic have_prev = 1'b0;
	logic prev_reset;
	logic prev_valid;
	pe_types_pkg::feature_vec_t prev_features;
	pe_types_pkg::feature_vec_t prev_out_features;

	task automatic push_expected(input result_vec_t vec);
		exp_q.push_back(vec);
	endtask

	function automatic int pending_count();
		return exp_q.size();
	endfunction

	function automatic int error_count();
		return result_errors + timing_errors + forward_errors + other_errors;
	endfunction

	task automatic report_other(input string msg);
		other_errors++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic print_counts();
		$display("Errors: result %0d, o_valid timing %0d, forwarding %0d, other %0d",
			result_errors, timing_errors, forward_errors, other_errors);
	endtask

	always @(posedge clk) begin
		result_vec_t want;
		if (have_prev) begin
			if (i_next_valid !== prev_valid) begin
				forward_errors++;
				$display("[FAIL] %0t o_next_valid expected %b got %b", $time, prev_valid,
					i_next_valid);
			end
			if (i_next_reset !== prev_reset) begin
				forward_errors++;
				$display("[FAIL] %0t o_next_reset expected %b got %b", $time, prev_reset,
					i_next_reset);
			end
			// Held through reset
			if (prev_reset) begin
				if (i_out_features !== prev_out_features) begin
					forward_errors++;
					$display("[FAIL] %0t o_features expected %h got %h", $time,
						prev_out_features, i_out_features);
				end
			end else if (i_out_features !== prev_features) begin
				forward_errors++;
				$display("[FAIL] %0t o_features expected %h got %h", $time, prev_features,
					i_out_features);
			end
			if (i_out_valid !== last_pipe[3]) begin
				timing_errors++;
				$display("[FAIL] %0t o_valid expected %b got %b", $time, last_pipe[3],
					i_out_valid);
			end
		end
		if (i_out_valid === 1'b1) begin
			if (exp_q.size() == 0) begin
				report_other("o_valid pulsed with no expected window result queued");
			end else begin
				want = exp_q.pop_front();
				for (int r = 0; r < ROWS; r++) begin
					if (i_result[r] !== want[r]) begin
						result_errors++;
						$display("[FAIL] %0t o_result[%0d] expected %h got %h", $time, r,
							want[r], i_result[r]);
					end
				end
			end
		end
		have_prev <= 1'b1;
		prev_reset <= i_reset;
		prev_valid <= i_valid;
		prev_features <= i_features;
		prev_out_features <= i_out_features;
		if (i_reset) begin
			beat_count <= 0;
			last_pipe <= '0;
		end else begin
			last_pipe <= {last_pipe[2:0], i_valid && (beat_count == WINDOW - 1)};
			if (i_valid) begin
				beat_count <= (beat_count == WINDOW - 1) ? 0 : beat_count + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/pe_patterns.txt ====
# W row word0..word3 (one word per address, lane 0 in low byte); B features lane 0..3
# G idle cycles; R max random gap before each beat; X reset cycles; E row 0..2 results
W 0 01010101 01010101 01010101 01010101
W 1 04030201 08070605 0c0b0a09 100f0e0d
W 2 ffffffff ffffffff ffffffff ffffffff
# Basic window
B 0001 0002 0003 0004
B 0005 0006 0007 0008
B 0010 0020 0030 0040
B 0100 0000 0000 0001
E 00001c5 00014bc 001c33b
# Two more windows back to back
B 0001 0001 0001 0001
B 0001 0001 0001 0001
B 0001 0001 0001 0001
B 0001 0001 0001 0001
E 0000010 0000088 0000ff0
B 0002 0000 0000 0000
B 0000 0002 0000 0000
B 0000 0000 0002 0000
B 0000 0000 0000 0002
E 0000008 0000044 00007f8
# Random gaps; row 2 dot product wraps past 2^23 and goes negative
R 5
B ffff ffff ffff ffff
B ffff ffff ffff ffff
B ffff ffff ffff ffff
B ffff ffff ffff ffff
E 00ffff0 087ff78 3feff010
# Reset in the middle of a window, then a full window from address 0
G 6
B ffff ffff ffff ffff
B ffff ffff ffff ffff
X 3
B 0001 0002 0003 0004
B 0005 0006 0007 0008
B 0010 0020 0030 0040
B 0100 0000 0000 0001
E 00001c5 00014bc 001c33b

// ==== sim/pe_tb.sv ====
`default_nettype none

module pe_tb;

	localparam int ROWS = 3;
	localparam int WINDOW = 4;
	localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;
	localparam int ADDR_W = (WINDOW > 1) ? $clog2(WINDOW) : 1;
	localparam int DRAIN_LIMIT = 200;

	logic clk;
	logic i_reset;
	logic i_valid;
	pe_types_pkg::feature_vec_t i_features;
	logic i_wt_wen;
	logic [ROW_W-1:0] i_wt_row;
	logic [ADDR_W-1:0] i_wt_addr;
	logic [pe_cfg_pkg::LANE_IDX_W-1:0] i_wt_lane;
	pe_types_pkg::weight_t i_wt_data;
	pe_types_pkg::feature_vec_t o_features;
	pe_types_pkg::acc_t [ROWS-1:0] o_result;
	logic o_valid;
	logic o_next_valid;
	logic o_next_reset;

	logic [31:0] rng_state;
	int gap_max;

	pe_top #(
		.ROWS(ROWS),
		.WINDOW(WINDOW)
	) u_dut (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_features(i_features),
		.i_wt_wen(i_wt_wen),
		.i_wt_row(i_wt_row),
		.i_wt_addr(i_wt_addr),
		.i_wt_lane(i_wt_lane),
		.i_wt_data(i_wt_data),
		.o_features(o_features),
		.o_result(o_result),
		.o_valid(o_valid),
		.o_next_valid(o_next_valid),
		.o_next_reset(o_next_reset)
	);

	pe_checker #(
		.ROWS(ROWS),
		.WINDOW(WINDOW)
	) u_check (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_features(i_features),
		.i_out_features(o_features),
		.i_result(o_result),
		.i_out_valid(o_valid),
		.i_next_valid(o_next_valid),
		.i_next_reset(o_next_reset)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Inputs change shortly after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic idle(input int n);
		i_valid = 1'b0;
		i_wt_wen = 1'b0;
		repeat (n) next_cycle();
	endtask

	// Features move during reset while o_features holds
	task automatic apply_reset(input int n);
		i_reset = 1'b1;
		i_features = ~i_features;
		idle(n);
		i_reset = 1'b0;
	endtask

	// Lane 0 of each address word sits in the low byte
	task automatic write_row(input int row, input logic [31:0] words [5]);
		for (int a = 0; a < WINDOW; a++) begin
			for (int l = 0; l < pe_cfg_pkg::LANES; l++) begin
				i_wt_wen = 1'b1;
				i_wt_row = ROW_W'(row);
				i_wt_addr = ADDR_W'(a);
				i_wt_lane = pe_cfg_pkg::LANE_IDX_W'(l);
				i_wt_data = words[a + 1][8 * l +: 8];
				next_cycle();
			end
		end
		i_wt_wen = 1'b0;
	endtask

	task automatic send_beat(input pe_types_pkg::feature_vec_t vec);
		int gap;
		gap = 0;
		if (gap_max > 0) begin
			rng_state = xorshift32(rng_state);
			gap = int'(rng_state % (gap_max + 1));
		end
		idle(gap);
		i_valid = 1'b1;
		i_features = vec;
		next_cycle();
		i_valid = 1'b0;
	endtask

	task automatic run_line(input string line);
		byte cmd;
		int n;
		logic [31:0] f [5];
		pe_types_pkg::feature_vec_t beat;
		pe_types_pkg::acc_t [ROWS-1:0] expect_vec;
		if (line.len() < 3 || line.getc(0) == "#") begin
			return;
		end
		cmd = line.getc(0);
		for (int i = 0; i < 5; i++) begin
			f[i] = '0;
		end
		n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h %h",
			f[0], f[1], f[2], f[3], f[4]);
		case (cmd)
			"W": write_row(int'(f[0]), f);
			"G": idle(int'(f[0]));
			"R": gap_max = int'(f[0]);
			"X": apply_reset(int'(f[0]));
			"B": begin
				for (int l = 0; l < pe_cfg_pkg::LANES; l++) begin
					beat[l] = f[l][15:0];
				end
				send_beat(beat);
			end
			"E": begin
				for (int r = 0; r < ROWS; r++) begin
					expect_vec[r] = f[r][pe_cfg_pkg::ACC_W-1:0];
				end
				u_check.push_expected(expect_vec);
			end
			default: begin
				u_check.report_other($sformatf("Unknown pattern line (%0d fields): %s",
					n, line));
			end
		endcase
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (u_check.pending_count() != 0 && cycles < DRAIN_LIMIT) begin
			next_cycle();
			cycles++;
		end
		if (u_check.pending_count() != 0) begin
			u_check.report_other($sformatf(
				"Timeout after %0d cycles, %0d window results never came",
				cycles, u_check.pending_count()));
		end
	endtask

	task automatic finish_run();
		u_check.print_counts();
		if (u_check.error_count() == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	endtask

	initial begin
		int fd;
		int n;
		string line;
		i_reset = 1'b1;
		i_valid = 1'b0;
		i_features = '0;
		i_wt_wen = 1'b0;
		i_wt_row = '0;
		i_wt_addr = '0;
		i_wt_lane = '0;
		i_wt_data = '0;
		rng_state = 32'd54163;
		gap_max = 0;
		apply_reset(10);
		fd = $fopen("sim/pe_patterns.txt", "r");
		if (fd == 0) begin
			u_check.report_other("Could not open the pattern file sim/pe_patterns.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 0) begin
					run_line(line);
				end
			end
			$fclose(fd);
			wait_drain();
			// Room for a stray o_valid to show up
			idle(8);
		end
		finish_run();
	end

endmodule

`default_nettype wire

// ==== verilog/pe_accumulator.sv ====
`default_nettype none

module pe_accumulator #(
	parameter int ROWS = 3
) (
	input wire clk,
	input wire i_reset,
	input wire i_dp_valid,
	input wire i_dp_last,
	input wire pe_types_pkg::dp_t [ROWS-1:0] i_dp,
	output pe_types_pkg::acc_t [ROWS-1:0] o_result,
	output logic o_valid
);

	localparam int EXT_W = pe_cfg_pkg::ACC_W - pe_cfg_pkg::DP_W;

	pe_types_pkg::acc_t sum_q [ROWS];
	pe_types_pkg::acc_t total_c [ROWS];

	// Dot product is signed once it reaches the accumulator
	always_comb begin
		for (int r = 0; r < ROWS; r++) begin
			total_c[r] = sum_q[r] + {{EXT_W{i_dp[r][pe_cfg_pkg::DP_W-1]}}, i_dp[r]};
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			for (int r = 0; r < ROWS; r++) begin
				sum_q[r] <= '0;
			end
		end else if (i_dp_valid) begin
			for (int r = 0; r < ROWS; r++) begin
				// Next window starts from zero
				sum_q[r] <= i_dp_last ? '0 : total_c[r];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_dp_valid && i_dp_last) begin
			for (int r = 0; r < ROWS; r++) begin
				o_result[r] <= total_c[r];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_dp_valid && i_dp_last;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pe_cfg_pkg.sv ====
`default_nettype none

package pe_cfg_pkg;

	// Datapath widths
	localparam int FEATURE_W = 16;
	localparam int WEIGHT_W = 8;

	// Dot product is kept modulo 2^DP_W
	localparam int DP_W = 24;

	// Window accumulator width
	localparam int ACC_W = 30;

	// Features taken per beat
	localparam int LANES = 4;
	localparam int LANE_IDX_W = 2;

endpackage

`default_nettype wire

// ==== verilog/pe_dot_array.sv ====
`default_nettype none

module pe_dot_array #(
	parameter int ROWS = 3
) (
	input wire clk,
	input wire i_reset,
	input wire i_beat,
	input wire i_last,
	input wire pe_types_pkg::feature_vec_t i_features,
	input wire pe_types_pkg::weight_vec_t [ROWS-1:0] i_weights,
	output logic o_dp_valid,
	output logic o_dp_last,
	output pe_types_pkg::dp_t [ROWS-1:0] o_dp
);

	localparam int PROD_W = pe_cfg_pkg::FEATURE_W + pe_cfg_pkg::WEIGHT_W;

	logic [PROD_W-1:0] prod_q [ROWS][pe_cfg_pkg::LANES];
	pe_types_pkg::dp_t sum_c [ROWS];
	logic beat_q;
	logic last_q;

	// Stage one, unsigned products
	always_ff @(posedge clk) begin
		for (int r = 0; r < ROWS; r++) begin
			for (int l = 0; l < pe_cfg_pkg::LANES; l++) begin
				prod_q[r][l] <= PROD_W'(i_features[l]) * PROD_W'(i_weights[r][l]);
			end
		end
	end

	// Lane sum wraps at DP_W bits
	always_comb begin
		for (int r = 0; r < ROWS; r++) begin
			sum_c[r] = '0;
			for (int l = 0; l < pe_cfg_pkg::LANES; l++) begin
				sum_c[r] = sum_c[r] + pe_cfg_pkg::DP_W'(prod_q[r][l]);
			end
		end
	end

	// Stage two
	always_ff @(posedge clk) begin
		for (int r = 0; r < ROWS; r++) begin
			o_dp[r] <= sum_c[r];
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			beat_q <= 1'b0;
			last_q <= 1'b0;
			o_dp_valid <= 1'b0;
			o_dp_last <= 1'b0;
		end else begin
			beat_q <= i_beat;
			last_q <= i_last;
			o_dp_valid <= beat_q;
			o_dp_last <= last_q;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pe_forward_stage.sv ====
`default_nettype none

module pe_forward_stage (
	input wire clk,
	input wire i_reset,
	input wire i_valid,
	input wire pe_types_pkg::feature_vec_t i_features,
	output pe_types_pkg::feature_vec_t o_features,
	output logic o_next_valid,
	output logic o_next_reset
);

	// Features hold their value while in reset
	always_ff @(posedge clk) begin
		if (!i_reset) begin
			o_features <= i_features;
		end
	end

	// Strobes for the next element in the chain, one cycle late
	always_ff @(posedge clk) begin
		o_next_valid <= i_valid;
		o_next_reset <= i_reset;
	end

endmodule

`default_nettype wire

// ==== verilog/pe_sequencer.sv ====
`default_nettype none

module pe_sequencer #(
	parameter int WINDOW = 4,
	localparam int ADDR_W = (WINDOW > 1) ? $clog2(WINDOW) : 1
) (
	input wire clk,
	input wire i_reset,
	input wire i_valid,
	output logic [ADDR_W-1:0] o_rd_addr,
	output logic o_beat,
	output logic o_last
);

	localparam logic [ADDR_W-1:0] LAST_IDX = ADDR_W'(WINDOW - 1);

	logic [ADDR_W-1:0] beat_idx;
	logic at_last;

	assign at_last = (beat_idx == LAST_IDX);

	// Memory is read with the index of the beat being sampled
	assign o_rd_addr = beat_idx;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			beat_idx <= '0;
		end else if (i_valid) begin
			if (at_last) begin
				beat_idx <= '0;
			end else begin
				beat_idx <= beat_idx + 1'b1;
			end
		end
	end

	// Tags line up with the registered weight read
	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_beat <= 1'b0;
			o_last <= 1'b0;
		end else begin
			o_beat <= i_valid;
			o_last <= i_valid && at_last;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/pe_top.sv ====
`default_nettype none

module pe_top #(
	parameter int ROWS = 3,
	parameter int WINDOW = 4,
	localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1,
	localparam int ADDR_W = (WINDOW > 1) ? $clog2(WINDOW) : 1
) (
	input wire clk,
	input wire i_reset,
	input wire i_valid,
	input wire pe_types_pkg::feature_vec_t i_features,

	// Weight load port
	input wire i_wt_wen,
	input wire [ROW_W-1:0] i_wt_row,
	input wire [ADDR_W-1:0] i_wt_addr,
	input wire [pe_cfg_pkg::LANE_IDX_W-1:0] i_wt_lane,
	input wire pe_types_pkg::weight_t i_wt_data,

	output pe_types_pkg::feature_vec_t o_features,
	output pe_types_pkg::acc_t [ROWS-1:0] o_result,
	output logic o_valid,
	output logic o_next_valid,
	output logic o_next_reset
);

	logic [ADDR_W-1:0] rd_addr;
	logic beat;
	logic last;
	pe_types_pkg::weight_vec_t [ROWS-1:0] weights;
	logic dp_valid;
	logic dp_last;
	pe_types_pkg::dp_t [ROWS-1:0] dp;

	pe_weight_load_if #(
		.ROWS(ROWS),
		.WINDOW(WINDOW)
	) wt_if ();

	assign wt_if.wen = i_wt_wen;
	assign wt_if.row = i_wt_row;
	assign wt_if.addr = i_wt_addr;
	assign wt_if.lane = i_wt_lane;
	assign wt_if.data = i_wt_data;

	pe_sequencer #(
		.WINDOW(WINDOW)
	) u_sequencer (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.o_rd_addr(rd_addr),
		.o_beat(beat),
		.o_last(last)
	);

	// Registered features also feed this element's dot array
	pe_forward_stage u_forward (
		.clk(clk),
		.i_reset(i_reset),
		.i_valid(i_valid),
		.i_features(i_features),
		.o_features(o_features),
		.o_next_valid(o_next_valid),
		.o_next_reset(o_next_reset)
	);

	pe_weight_mem #(
		.ROWS(ROWS),
		.WINDOW(WINDOW)
	) u_weight_mem (
		.clk(clk),
		.wt(wt_if.dst),
		.i_rd_addr(rd_addr),
		.o_weights(weights)
	);

	pe_dot_array #(
		.ROWS(ROWS)
	) u_dot_array (
		.clk(clk),
		.i_reset(i_reset),
		.i_beat(beat),
		.i_last(last),
		.i_features(o_features),
		.i_weights(weights),
		.o_dp_valid(dp_valid),
		.o_dp_last(dp_last),
		.o_dp(dp)
	);

	pe_accumulator #(
		.ROWS(ROWS)
	) u_accumulator (
		.clk(clk),
		.i_reset(i_reset),
		.i_dp_valid(dp_valid),
		.i_dp_last(dp_last),
		.i_dp(dp),
		.o_result(o_result),
		.o_valid(o_valid)
	);

endmodule

`default_nettype wire

// ==== verilog/pe_types_pkg.sv ====
`default_nettype none

package pe_types_pkg;

	// Scalar words
	typedef logic [pe_cfg_pkg::FEATURE_W-1:0] feature_t;
	typedef logic [pe_cfg_pkg::WEIGHT_W-1:0] weight_t;

	// Per-row results
	typedef logic [pe_cfg_pkg::DP_W-1:0] dp_t;
	typedef logic [pe_cfg_pkg::ACC_W-1:0] acc_t;

	// One beat of features, lane 0 in the low bits
	typedef feature_t [pe_cfg_pkg::LANES-1:0] feature_vec_t;

	// Weights for all lanes of one row at one address
	typedef weight_t [pe_cfg_pkg::LANES-1:0] weight_vec_t;

endpackage

`default_nettype wire

// ==== verilog/pe_weight_load_if.sv ====
`default_nettype none

interface pe_weight_load_if #(
	parameter int ROWS = 3,
	parameter int WINDOW = 4
);

	localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;
	localparam int ADDR_W = (WINDOW > 1) ? $clog2(WINDOW) : 1;

	// One weight written per clock while wen is high
	logic wen;
	logic [ROW_W-1:0] row;
	logic [ADDR_W-1:0] addr;
	logic [pe_cfg_pkg::LANE_IDX_W-1:0] lane;
	pe_types_pkg::weight_t data;

	modport src (
		output wen, row, addr, lane, data
	);

	modport dst (
		input wen, row, addr, lane, data
	);

endinterface

`default_nettype wire

// ==== verilog/pe_weight_mem.sv ====
`default_nettype none

module pe_weight_mem #(
	parameter int ROWS = 3,
	parameter int WINDOW = 4,
	localparam int ADDR_W = (WINDOW > 1) ? $clog2(WINDOW) : 1
) (
	input wire clk,
	pe_weight_load_if.dst wt,
	input wire [ADDR_W-1:0] i_rd_addr,
	output pe_types_pkg::weight_vec_t [ROWS-1:0] o_weights
);

	pe_types_pkg::weight_t mem [ROWS][WINDOW][pe_cfg_pkg::LANES];

	logic wr_in_range;

	// Rows or addresses past the end are dropped
	assign wr_in_range = (int'(wt.row) < ROWS) && (int'(wt.addr) < WINDOW);

	always_ff @(posedge clk) begin
		if (wt.wen && wr_in_range) begin
			mem[wt.row][wt.addr][wt.lane] <= wt.data;
		end
	end

	// All rows read the same address
	always_ff @(posedge clk) begin
		for (int r = 0; r < ROWS; r++) begin
			for (int l = 0; l < pe_cfg_pkg::LANES; l++) begin
				o_weights[r][l] <= mem[r][i_rd_addr][l];
			end
		end
	end

endmodule

`default_nettype wire
